/* feat_pkg.sv */
package feat_pkg;

    // image geometry
    localparam int IMG_ROWS  = 16;                  // rows per image
    localparam int IMG_COLS  = 16;                  // pixels per row
    localparam int PIX_W     = 8;                   // bits per pixel
    localparam int KPT_DEPTH = 256;                 // one slot per pixel at most

    typedef logic [PIX_W-1:0]              pixel_t;     // one pixel
    typedef logic [IMG_COLS*PIX_W-1:0]     row_t;       // col 0 in low bits
    typedef logic [$clog2(IMG_ROWS)-1:0]   row_addr_t;  // row index
    typedef logic [7:0]                    kpt_t;       // {row, col} nibbles
    typedef logic [$clog2(KPT_DEPTH)-1:0]  kpt_addr_t;  // keypoint slot
    typedef logic [$clog2(KPT_DEPTH):0]    kpt_count_t; // 0..256 inclusive
    typedef logic [7:0]                    thresh_t;    // detection threshold

    // threshold control
    localparam thresh_t THRESH_INIT = 8'd16;        // after reset or adapt off
    localparam thresh_t THRESH_STEP = 8'd4;         // per run adjustment
    localparam thresh_t THRESH_MIN  = 8'd4;         // lower clamp
    localparam thresh_t THRESH_MAX  = 8'd60;        // upper clamp

    // target keypoint bands
    localparam kpt_count_t TGT_LO_FAST = 9'd8;      // high throughput band
    localparam kpt_count_t TGT_HI_FAST = 9'd24;
    localparam kpt_count_t TGT_LO_ACC  = 9'd24;     // high accuracy band
    localparam kpt_count_t TGT_HI_ACC  = 9'd64;

endpackage

/* row_mem.sv */
`timescale 1ns/1ps
module row_mem #(
    parameter int   WIDTH = 128,                    // word width
    parameter int   DEPTH = 16,                     // number of words
    localparam int  AW    = $clog2(DEPTH)           // address width
) (
    input  logic             clk,
    input  logic             we,
    input  logic [AW-1:0]    waddr,
    input  logic [WIDTH-1:0] wdata,
    input  logic [AW-1:0]    raddr,
    output logic [WIDTH-1:0] rdata
);

    logic [WIDTH-1:0] mem [DEPTH];                  // storage array

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;                    // single write port
        end
        rdata <= mem[raddr];                        // data one cycle after address
    end

    // writes must land inside the array
    assert property (@(posedge clk) we |-> (int'(waddr) < DEPTH))
        else $error("row_mem write address %0d beyond depth %0d", waddr, DEPTH);

endmodule

/* gauss_blur.sv */
`timescale 1ns/1ps
module gauss_blur (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                blur_start,     // one cycle kick from core
    output feat_pkg::row_addr_t img_raddr,
    input  feat_pkg::row_t      img_rdata,
    output logic                blur_we,
    output feat_pkg::row_addr_t blur_waddr,
    output feat_pkg::row_t      blur_wdata,
    output logic                blur_done       // pulse after last row written
);
    import feat_pkg::*;

    localparam int LAST_STEP = IMG_ROWS + 1;    // zero row below 15 shifted in

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,                                // address out, data next cycle
        S_WAIT,                                 // shift fetched row into window
        S_WRITE                                 // write row r, next fetch in flight
    } state_t;

    state_t     state;
    logic [4:0] step;                           // rows shifted in so far
    logic [4:0] wr_row;                         // row under the window centre
    row_t       win_top;                        // row r-1
    row_t       win_mid;                        // row r
    row_t       win_bot;                        // row r+1
    logic [9:0] vsum [IMG_COLS];                // vertical 1 2 1 per column
    pixel_t     blur_px [IMG_COLS];

    assign img_raddr  = step[$bits(row_addr_t)-1:0];  // fetch pointer, wraps past 15
    assign wr_row     = step - 5'd2;                  // window lags fetch by two
    assign blur_we    = (state == S_WRITE);
    assign blur_waddr = wr_row[$bits(row_addr_t)-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            step      <= '0;
            blur_done <= 1'b0;
        end else begin
            blur_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (blur_start) begin
                        step  <= '0;
                        state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    step  <= step + 5'd1;
                    // window incomplete after row 0 alone
                    state <= (step == 5'd0) ? S_FETCH : S_WRITE;
                end
                S_WRITE: begin
                    if (int'(step) == LAST_STEP) begin
                        state     <= S_IDLE;
                        blur_done <= 1'b1;      // row 15 just went out
                    end else begin
                        state <= S_WAIT;        // next row already addressed
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // three row window, zero rows above 0 and below 15
    always_ff @(posedge clk) begin
        if (state == S_IDLE && blur_start) begin
            win_top <= '0;
            win_mid <= '0;
            win_bot <= '0;
        end else if (state == S_WAIT) begin
            win_top <= win_mid;
            win_mid <= win_bot;
            win_bot <= (int'(step) < IMG_ROWS) ? img_rdata : '0;
        end
    end

    // separable kernel, vertical then horizontal
    for (genvar c = 0; c < IMG_COLS; c++) begin : g_col
        logic [11:0] left;                      // column c-1 term
        logic [11:0] right;                     // column c+1 term
        logic [11:0] sum;                       // full 3x3 weighted sum

        assign vsum[c] = 10'(win_top[c*PIX_W +: PIX_W])
                       + 10'({win_mid[c*PIX_W +: PIX_W], 1'b0})
                       + 10'(win_bot[c*PIX_W +: PIX_W]);

        if (c == 0) begin : g_left_edge
            assign left = '0;                   // zero fill left of col 0
        end else begin : g_left
            assign left = 12'(vsum[c-1]);
        end

        if (c == IMG_COLS-1) begin : g_right_edge
            assign right = '0;                  // zero fill right of col 15
        end else begin : g_right
            assign right = 12'(vsum[c+1]);
        end

        assign sum        = left + 12'({vsum[c], 1'b0}) + right;
        assign blur_px[c] = sum[11:4];          // divide by 16, truncate
    end

    always_comb begin
        for (int c = 0; c < IMG_COLS; c++) begin
            blur_wdata[c*PIX_W +: PIX_W] = blur_px[c];
        end
    end

    // step sequencing must never address past the last row
    assert property (@(posedge clk) disable iff (!rst_n)
                     blur_we |-> (int'(wr_row) < IMG_ROWS))
        else $error("gauss_blur writing row %0d", wr_row);

endmodule

/* keypoint_detect.sv */
`timescale 1ns/1ps
module keypoint_detect (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 detect_start,  // one cycle kick from core
    input  logic                 filter_on,
    input  feat_pkg::thresh_t    threshold,
    output feat_pkg::row_addr_t  img_raddr,
    input  feat_pkg::row_t       img_rdata,
    output feat_pkg::row_addr_t  blur_raddr,
    input  feat_pkg::row_t       blur_rdata,
    output logic                 kpt_we,
    output feat_pkg::kpt_addr_t  kpt_waddr,
    output feat_pkg::kpt_t       kpt_wdata,
    output feat_pkg::kpt_count_t kpt_count,
    output logic                 detect_done    // pulse once count is final
);
    import feat_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,                                // both rows addressed
        S_SCAN                                  // one column per cycle
    } state_t;

    state_t                      state;
    row_addr_t                   row;
    logic [$clog2(IMG_COLS)-1:0] col;
    thresh_t                     thr_q;         // held for the whole pass
    thresh_t                     thr_eff;
    pixel_t                      org_px;
    pixel_t                      blr_px;
    pixel_t                      diff;
    logic                        hit;
    logic                        last_col;

    // read data stays stable while the row address holds
    assign img_raddr  = row;
    assign blur_raddr = row;

    assign org_px   = img_rdata[col*PIX_W +: PIX_W];
    assign blr_px   = blur_rdata[col*PIX_W +: PIX_W];
    assign diff     = (org_px > blr_px) ? org_px - blr_px : blr_px - org_px;
    assign thr_eff  = filter_on ? thr_q : '0;   // unfiltered means any change
    assign hit      = (state == S_SCAN) && (diff > thr_eff);
    assign last_col = (int'(col) == IMG_COLS-1);

    assign kpt_we    = hit;
    assign kpt_waddr = kpt_count[$bits(kpt_addr_t)-1:0];
    assign kpt_wdata = {row, col};              // raster position

    always_ff @(posedge clk) begin
        if (detect_start) begin
            thr_q <= threshold;                 // sampled once per run
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            row         <= '0;
            col         <= '0;
            kpt_count   <= '0;
            detect_done <= 1'b0;
        end else begin
            detect_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (detect_start) begin
                        row       <= '0;
                        col       <= '0;
                        kpt_count <= '0;        // fresh count each run
                        state     <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    state <= S_SCAN;
                end
                S_SCAN: begin
                    if (hit) begin
                        kpt_count <= kpt_count + 1'b1;
                    end
                    col <= col + 1'b1;          // wraps to 0 after col 15
                    if (last_col) begin
                        if (int'(row) == IMG_ROWS-1) begin
                            state       <= S_IDLE;
                            detect_done <= 1'b1;
                        end else begin
                            row   <= row + 1'b1;
                            state <= S_FETCH;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // one slot per pixel, so the count can never pass the memory depth
    assert property (@(posedge clk) disable iff (!rst_n)
                     int'(kpt_count) <= KPT_DEPTH)
        else $error("keypoint_detect count %0d overflows", kpt_count);

endmodule

/* adaptive_threshold.sv */
`timescale 1ns/1ps
module adaptive_threshold (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 adapt_on,
    input  logic                 adapt_mode,    // 0 throughput, 1 accuracy
    input  logic                 detect_done,   // update strobe
    input  feat_pkg::kpt_count_t kpt_count,
    output feat_pkg::thresh_t    threshold
);
    import feat_pkg::*;

    kpt_count_t tgt_lo;
    kpt_count_t tgt_hi;
    thresh_t    thr_up;                         // raised and clamped
    thresh_t    thr_dn;                         // lowered and clamped

    assign tgt_lo = adapt_mode ? TGT_LO_ACC : TGT_LO_FAST;
    assign tgt_hi = adapt_mode ? TGT_HI_ACC : TGT_HI_FAST;

    // compare before stepping so the 8 bit sum never wraps
    assign thr_up = (threshold > THRESH_MAX - THRESH_STEP) ? THRESH_MAX
                                                           : threshold + THRESH_STEP;
    assign thr_dn = (threshold < THRESH_MIN + THRESH_STEP) ? THRESH_MIN
                                                           : threshold - THRESH_STEP;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            threshold <= THRESH_INIT;
        end else if (detect_done) begin
            if (!adapt_on) begin
                threshold <= THRESH_INIT;       // back to default
            end else if (kpt_count > tgt_hi) begin
                threshold <= thr_up;            // too many keypoints
            end else if (kpt_count < tgt_lo) begin
                threshold <= thr_dn;            // too few keypoints
            end
        end
    end

    // init value sits inside the clamp band, so this holds across all runs
    assert property (@(posedge clk) disable iff (!rst_n)
                     threshold >= THRESH_MIN && threshold <= THRESH_MAX)
        else $error("adaptive_threshold out of band at %0d", threshold);

endmodule

/* feat_core.sv */
`timescale 1ns/1ps
module feat_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,         // ignored unless idle
    output logic                 done,
    input  logic                 filter_on,
    input  logic                 adapt_on,
    input  logic                 adapt_mode,
    input  logic                 img_we,        // honored only in idle
    input  feat_pkg::row_addr_t  img_addr,
    input  feat_pkg::row_t       img_din,
    input  feat_pkg::kpt_addr_t  kpt_addr,
    output feat_pkg::kpt_t       kpt_dout,
    output feat_pkg::kpt_count_t kpt_count,
    output feat_pkg::thresh_t    threshold
);
    import feat_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BLUR,
        ST_DETECT,
        ST_FINISH                               // done cycle, then idle
    } state_t;

    state_t    state;
    logic      blur_start, blur_done;
    logic      detect_start, detect_done;
    logic      img_mem_we;
    row_addr_t img_raddr, gb_img_raddr, kd_img_raddr;
    row_t      img_rdata;
    logic      blur_we;
    row_addr_t blur_waddr, blur_raddr;
    row_t      blur_wdata, blur_rdata;
    logic      kpt_we;
    kpt_addr_t kpt_waddr;
    kpt_t      kpt_wdata;

    assign blur_start   = (state == ST_IDLE) && start;
    assign detect_start = (state == ST_BLUR) && blur_done;
    assign done         = (state == ST_FINISH);
    assign img_mem_we   = (state == ST_IDLE) && img_we;   // no loads mid run

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:   if (blur_start) state <= ST_BLUR;
                ST_BLUR:   if (blur_done) state <= ST_DETECT;
                ST_DETECT: if (detect_done) state <= ST_FINISH;
                default:   state <= ST_IDLE;   // finish lasts one cycle
            endcase
        end
    end

    always_comb begin
        case (state)
            ST_BLUR:   img_raddr = gb_img_raddr;
            ST_DETECT: img_raddr = kd_img_raddr;
            default:   img_raddr = '0;
        endcase
    end

    row_mem #(.WIDTH($bits(row_t)), .DEPTH(IMG_ROWS)) u_img_mem (
        .clk(clk), .we(img_mem_we), .waddr(img_addr), .wdata(img_din),
        .raddr(img_raddr), .rdata(img_rdata)
    );

    row_mem #(.WIDTH($bits(row_t)), .DEPTH(IMG_ROWS)) u_blur_mem (
        .clk(clk), .we(blur_we), .waddr(blur_waddr), .wdata(blur_wdata),
        .raddr(blur_raddr), .rdata(blur_rdata)
    );

    row_mem #(.WIDTH($bits(kpt_t)), .DEPTH(KPT_DEPTH)) u_kpt_mem (
        .clk(clk), .we(kpt_we), .waddr(kpt_waddr), .wdata(kpt_wdata),
        .raddr(kpt_addr), .rdata(kpt_dout)       // readback port for host
    );

    gauss_blur u_gauss_blur (
        .clk(clk), .rst_n(rst_n), .blur_start(blur_start),
        .img_raddr(gb_img_raddr), .img_rdata(img_rdata),
        .blur_we(blur_we), .blur_waddr(blur_waddr), .blur_wdata(blur_wdata),
        .blur_done(blur_done)
    );

    keypoint_detect u_keypoint_detect (
        .clk(clk), .rst_n(rst_n), .detect_start(detect_start),
        .filter_on(filter_on), .threshold(threshold),
        .img_raddr(kd_img_raddr), .img_rdata(img_rdata),
        .blur_raddr(blur_raddr), .blur_rdata(blur_rdata),
        .kpt_we(kpt_we), .kpt_waddr(kpt_waddr), .kpt_wdata(kpt_wdata),
        .kpt_count(kpt_count), .detect_done(detect_done)
    );

    adaptive_threshold u_adaptive_threshold (
        .clk(clk), .rst_n(rst_n), .adapt_on(adapt_on), .adapt_mode(adapt_mode),
        .detect_done(detect_done), .kpt_count(kpt_count), .threshold(threshold)
    );

    // sub block strobes only arrive in the phase that launched them
    assert property (@(posedge clk) disable iff (!rst_n)
                     (!blur_done || state == ST_BLUR) && (!detect_done || state == ST_DETECT))
        else $error("feat_core stray done strobe in state %0d", state);

endmodule

/* tb_feat_core.sv */
`timescale 1ns/1ps
module tb_feat_core;
    import feat_pkg::*;

    localparam int STIM_WORDS   = 75;           // images, run count, records, keypoints
    localparam int IMG_A_BASE   = 0;
    localparam int IMG_B_BASE   = 16;
    localparam int RUNS_AT      = 32;           // word holding the number of runs
    localparam int DONE_TIMEOUT = 2000;         // cycles, one run takes about 330
    localparam int QUIET_CYCLES = 400;          // longer than a full run
    localparam int STRAY_DELAY  = 20;           // second start lands mid blur

    logic       clk;
    logic       rst_n;
    logic       start;
    logic       done;
    logic       filter_on;
    logic       adapt_on;
    logic       adapt_mode;
    logic       img_we;
    row_addr_t  img_addr;
    row_t       img_din;
    kpt_addr_t  kpt_addr;
    kpt_t       kpt_dout;
    kpt_count_t kpt_count;
    thresh_t    threshold;

    logic [127:0] stim [STIM_WORDS];            // whole stim file

    feat_core DUT (
        .clk(clk), .rst_n(rst_n), .start(start), .done(done),
        .filter_on(filter_on), .adapt_on(adapt_on), .adapt_mode(adapt_mode),
        .img_we(img_we), .img_addr(img_addr), .img_din(img_din),
        .kpt_addr(kpt_addr), .kpt_dout(kpt_dout),
        .kpt_count(kpt_count), .threshold(threshold)
    );

    always #4 clk = ~clk;                       // 8 ns period

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_count(input kpt_count_t got, input kpt_count_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s: kpt_count %0d, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_kpt(input kpt_t got, input kpt_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s: keypoint %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_thresh(input thresh_t got, input thresh_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s: threshold %0d, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    task automatic load_image(input int base);
        for (int r = 0; r < IMG_ROWS; r++) begin
            @(posedge clk);
            img_we   <= 1'b1;
            img_addr <= row_addr_t'(r);
            img_din  <= stim[base + r];         // col 0 in low byte
        end
        @(posedge clk);
        img_we <= 1'b0;
    endtask

    task automatic pulse_start;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(input string what);
        int cycles = 0;
        @(negedge clk);                         // sample away from the edge
        while (!done) begin
            if (cycles == DONE_TIMEOUT) begin
                abort_run($sformatf("timeout: %s saw no done pulse within %0d cycles",
                                    what, DONE_TIMEOUT));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // done must stay low until the core is started again
    task automatic expect_quiet(input string what);
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            if (done) begin
                abort_run($sformatf("%s: done pulsed a second time", what));
            end
        end
    endtask

    task automatic read_kpt(input int idx, output kpt_t got);
        @(posedge clk);
        kpt_addr <= kpt_addr_t'(idx);
        @(posedge clk);                         // registered read
        @(negedge clk);
        got = kpt_dout;
    endtask

    initial begin
        logic [47:0] rec;                       // one run record
        int          ptr;
        int          n_runs;
        int          n_kpts;
        int          base;
        int          cur_base;
        kpt_t        got;
        string       tag;

        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        filter_on  = 1'b0;
        adapt_on   = 1'b0;
        adapt_mode = 1'b0;
        img_we     = 1'b0;
        img_addr   = '0;
        img_din    = '0;
        kpt_addr   = '0;
        $readmemh("feat_stim.txt", stim);

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (done) begin
            abort_run("done was high right after reset");
        end
        check_thresh(threshold, THRESH_INIT, "after reset");

        n_runs   = int'(stim[RUNS_AT][7:0]);
        ptr      = RUNS_AT + 1;
        cur_base = -1;
        for (int run = 1; run <= n_runs; run++) begin
            rec  = stim[ptr][47:0];
            ptr++;
            tag  = $sformatf("run %0d", run);
            base = rec[32] ? IMG_B_BASE : IMG_A_BASE;
            if (base != cur_base) begin
                load_image(base);               // core idle between runs
                cur_base = base;
            end
            @(posedge clk);
            filter_on  <= rec[44];
            adapt_on   <= rec[40];
            adapt_mode <= rec[36];
            pulse_start;
            if (rec[28]) begin
                repeat (STRAY_DELAY) @(posedge clk);
                pulse_start;                    // must be ignored mid run
            end
            wait_done(tag);
            check_count(kpt_count, kpt_count_t'(rec[27:16]), tag);
            check_thresh(threshold, rec[15:8], tag);
            expect_quiet(tag);
            n_kpts = int'(rec[7:0]);
            for (int k = 0; k < n_kpts; k++) begin
                read_kpt(k, got);
                check_kpt(got, stim[ptr][7:0], $sformatf("%s slot %0d", tag, k));
                ptr++;
            end
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

/* feat_stim.txt */
// words 0-15 image A, 16-31 image B, one row per word, pixel of col 15 first
// word 32 run count, then per run: filter_adapt_mode_img_stray_count_thresh_nkpt + keypoints
0                                                // A row 0
0                                                // A row 1
0                                                // A row 2
00_00_00_00_00_00_00_00_00_00_00_a0_00_00_00_00  // A row 3, spot at col 4
0                                                // A row 4
0                                                // A row 5
0                                                // A row 6
0                                                // A row 7
0                                                // A row 8
0                                                // A row 9
00_00_00_00_50_00_00_00_00_00_00_00_00_00_00_00  // A row 10, spot at col 11
0                                                // A row 11
0                                                // A row 12
0                                                // A row 13
0                                                // A row 14
0                                                // A row 15
0                                                // B row 0
00_00_b0_00_00_b0_00_00_b0_00_00_b0_00_00_b0_00  // B row 1, cols 1 4 7 10 13
0                                                // B row 2
0                                                // B row 3
00_00_b0_00_00_b0_00_00_b0_00_00_b0_00_00_b0_00  // B row 4
0                                                // B row 5
0                                                // B row 6
00_00_b0_00_00_b0_00_00_b0_00_00_b0_00_00_b0_00  // B row 7
0                                                // B row 8
0                                                // B row 9
00_00_b0_00_00_b0_00_00_b0_00_00_b0_00_00_b0_00  // B row 10
0                                                // B row 11
0                                                // B row 12
00_00_b0_00_00_b0_00_00_b0_00_00_b0_00_00_b0_00  // B row 13
0                                                // B row 14
0                                                // B row 15
a                                                // ten runs
0_0_0_0_0_012_10_12 23 24 25 33 34 35 43 44 45 9a 9b 9c aa ab ac ba bb bc  // A unfiltered
1_0_0_0_0_006_10_06 24 33 34 35 44 ab            // A at threshold 16
1_1_0_1_0_07d_14_00                              // B held 16
1_1_0_1_0_07d_18_00                              // B held 20
1_1_0_1_0_019_1c_00                              // B held 24, side pixels drop out
1_1_1_0_0_002_18_02 34 ab                        // A held 28, spot centres only
1_1_1_0_0_002_14_00                              // A held 24
1_1_1_0_0_002_10_00                              // A held 20
1_1_1_0_0_006_0c_00                              // A held 16
1_0_1_0_1_006_10_06 24 33 34 35 44 ab            // A held 12, adapt off, stray start

/* vlog.f */
feat_pkg.sv
row_mem.sv
gauss_blur.sv
keypoint_detect.sv
adaptive_threshold.sv
feat_core.sv
tb_feat_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the feat_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_feat_core -f vlog.f -o sim_feat_core \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_feat_core > sim.log 2>&1 || true
cat sim.log
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
